// File: barrel_fetchbuf.f
hw/fetch_pkg.sv
hw/decompress_table.sv
hw/thread_fetch_lane.sv
hw/fetch_pair_buffer.sv
hw/barrel_fetchbuf.sv
dv/tb_clock_gen.sv
dv/barrel_fetchbuf_properties.sv
dv/barrel_fetchbuf_tb.sv

// File: dv/barrel_fetchbuf_properties.sv
// barrel fetch buffer port properties
// reset state, bus ack, stall stability and legal takes
`timescale 1ns/1ps

module barrel_fetchbuf_properties
	import fetch_pkg::*;
(
	input logic              clk,
	input logic              rst,
	input logic              cs_i,
	input logic              cyc_i,
	input logic              stb_i,
	input logic              ack_i,
	input logic              fill_ready_i,	// internal pair store ready
	input logic [1:0]        take_i,
	input logic [1:0]        slot_valid_i,
	input logic [ADDR_W-1:0] slot_pc0_i,
	input logic [ADDR_W-1:0] slot_pc1_i,
	input logic [ADDR_W-1:0] pc0_i,
	input logic [ADDR_W-1:0] pc1_i
);

	// ========================================================================
	// bus and reset
	// ========================================================================
	// zero wait state ack, reset or not
	ack_follows_bus: assert property (@(posedge clk)
		ack_i == (cs_i & cyc_i & stb_i))
		else $error("bus ack does not follow cs, cyc and stb");

	// first edge out of reset still shows the reset state
	reset_state: assert property (@(posedge clk)
		$fell(rst) |-> (slot_valid_i == 2'b00) && (pc0_i == RST_PC) && (pc1_i == RST_PC))
		else $error("state after reset is wrong");

	// ========================================================================
	// back-pressure
	// ========================================================================
	stall_holds: assert property (@(posedge clk) disable iff (rst)
		(!fill_ready_i && take_i == 2'b00) |=>
			$stable(slot_valid_i) && $stable(slot_pc0_i) && $stable(slot_pc1_i)
			&& $stable(pc0_i) && $stable(pc1_i))
		else $error("slots or fetch pc moved while stalled");

	// second take only on top of the first, with both slots full
	take_legal: assume property (@(posedge clk) disable iff (rst)
		take_i[1] |-> take_i[0] && (slot_valid_i == 2'b11))
		else $error("illegal second slot take");

endmodule

// File: dv/barrel_fetchbuf_tb.sv
// barrel fetch buffer testbench
// cache model, table loads over the bus, random fetch and issue,
// irq holds and back-pressure, checked against an ordered scoreboard
`timescale 1ns/1ps

module barrel_fetchbuf_tb
	import fetch_pkg::*;
();

	localparam int TPL            = 16;	// threads per lane
	localparam int TAW            = 12;	// table index width
	localparam int PHASE_CYCLES   = 2000;
	localparam int TIMEOUT_CYCLES = (1 << TAW) + 5 * PHASE_CYCLES;

	logic                    clk, rst;
	logic                    cs, cyc, stb, we;
	logic [BUS_AW-1:0]       adr;
	logic [INSN_W-1:0]       dat;
	logic [2*TPL-1:0]        irq_hold;
	logic [ADDR_W-1:0]       pc_o [NUM_LANES];
	logic [INSN_W-1:0]       insn [NUM_LANES];
	logic [NUM_LANES-1:0]    phit;
	logic [INSN_W-1:0]       codebuf [NUM_LANES];
	logic [1:0]              slot_valid, slot_dc, take;
	logic [INSN_W-1:0]       slot_instr [2];
	logic [ADDR_W-1:0]       slot_pc [2];
	logic [TID_W-1:0]        slot_tid [2];
	integer                  seed = 32'hc4a5;

	// scoreboard state
	logic [INSN_W-1:0] tb_table [1 << TAW];	// last written table words
	logic [ADDR_W-1:0] m_pc [NUM_LANES][TPL];	// modelled thread pcs
	int                m_idx [NUM_LANES];	// modelled thread rotation
	logic [1:0]        m_pairs [$];	// modelled filled pairs, head first
	logic [INSN_W-1:0] q_instr [$];	// expected issue order
	logic [ADDR_W-1:0] q_pc [$];
	logic [TID_W-1:0]  q_tid [$];
	logic              q_dc [$];

	tb_clock_gen clk_gen_i (.clk_o(clk), .rst_o(rst));

	barrel_fetchbuf #(
		.THREADS_PER_LANE (TPL),
		.TABLE_AW         (TAW)
	) dut_i (
		.clk (clk), .rst (rst),
		.cs_i (cs), .cyc_i (cyc), .stb_i (stb), .we_i (we),
		.adr_i (adr), .dat_i (dat), .ack_o (),
		.irq_hold_i (irq_hold),
		.pc_o (pc_o), .insn_i (insn), .phit_i (phit), .codebuf_i (codebuf),
		.slot_valid_o (slot_valid), .slot_instr_o (slot_instr),
		.slot_pc_o (slot_pc), .slot_tid_o (slot_tid), .slot_dc_o (slot_dc),
		.take_i (take)
	);

	bind barrel_fetchbuf barrel_fetchbuf_properties props_i (
		.clk (clk), .rst (rst), .cs_i (cs_i), .cyc_i (cyc_i), .stb_i (stb_i),
		.ack_i (ack_o), .fill_ready_i (fill_ready), .take_i (take_i),
		.slot_valid_i (slot_valid_o), .slot_pc0_i (slot_pc_o[0]),
		.slot_pc1_i (slot_pc_o[1]), .pc0_i (pc_o[0]), .pc1_i (pc_o[1])
	);

	// ========================================================================
	// cache model and reference rules
	// ========================================================================
	function automatic logic [INSN_W-1:0] cache_word(input logic [ADDR_W-1:0] pc);
		logic [6:0] op;
		case (pc[5:4])
			2'd0:    op = 7'h01;	// plain
			2'd1:    op = OP_CMP_A;
			2'd2:    op = OP_CMP_B;
			default: op = OP_EXEC;
		endcase
		return {pc[31:3], op};	// body from pc bits
	endfunction

	function automatic logic [INSN_W-1:0] codebuf_word(input logic [ADDR_W-1:0] pc);
		return {4'h0, ~pc};
	endfunction

	function automatic logic [INSN_W-1:0] fill_word(input int idx);
		return {12'(idx), 24'(idx * 24'h5a3d1) ^ 24'hc3a55a};	// whole index used
	endfunction

	always_comb
	begin
		for (int l = 0; l < NUM_LANES; l++)
		begin
			insn[l]    = cache_word(pc_o[l]);
			codebuf[l] = codebuf_word(pc_o[l]);
		end
	end

	task automatic fail_check(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// head of the scoreboard against one issue slot
	task automatic check_slot(input int s);
		assert (q_instr.size() > 0)
			else fail_check("slot taken with nothing expected");
		assert (slot_instr[s] == q_instr[0] && slot_pc[s] == q_pc[0]
			&& slot_tid[s] == q_tid[0] && slot_dc[s] == q_dc[0])
			else fail_check($sformatf("slot %0d got %h pc %h tid %0d dc %b, want %h %h %0d %b",
				s, slot_instr[s], slot_pc[s], slot_tid[s], slot_dc[s],
				q_instr[0], q_pc[0], q_tid[0], q_dc[0]));
		void'(q_instr.pop_front());
		void'(q_pc.pop_front());
		void'(q_tid.pop_front());
		void'(q_dc.pop_front());
	endtask

	// ========================================================================
	// one cycle of stimulus and scoring
	// ========================================================================
	task automatic step(input bit fetch_en, input bit take_en, input bit irq_en,
		input bit wr_en);
		logic [TAW-1:0]    widx;
		logic [INSN_W-1:0] w, wdat;
		logic [ADDR_W-1:0] pc;
		logic [TID_W-1:0]  tid;
		logic [1:0]        head_exp;	// modelled head pair valids
		bit                wr;
		bit                ready;	// modelled room in the pair store
		@(negedge clk);
		for (int l = 0; l < NUM_LANES; l++)
			phit[l] = fetch_en && (($random(seed) % 5) != 0);	// about 80%
		if (!irq_en)
			irq_hold = '0;
		else if (($random(seed) % 8) == 0)
			irq_hold = $random(seed) & $random(seed);	// sparse holds
		wr   = wr_en && (($random(seed) % 8) == 0);
		widx = TAW'($random(seed));
		wdat = {4'($random(seed)), 32'($random(seed))};
		{cs, cyc, stb, we} = {4{wr}};
		adr  = {widx, 3'b000};
		dat  = wdat;
		take = 2'b00;
		if (take_en && slot_valid == 2'b11)
		begin
			take[0] = 1'($random(seed));
			take[1] = take[0] & 1'($random(seed));
		end
		else if (take_en && slot_valid != 2'b00)
			take[0] = 1'($random(seed));
		#1;
		for (int l = 0; l < NUM_LANES; l++)
			assert (pc_o[l] == m_pc[l][m_idx[l]])
				else fail_check($sformatf("lane %0d pc %h want %h", l, pc_o[l],
					m_pc[l][m_idx[l]]));
		head_exp = (m_pairs.size() != 0) ? m_pairs[0] : 2'b00;
		assert (slot_valid == head_exp)
			else fail_check($sformatf("slot valid %b want %b", slot_valid, head_exp));
		if (take[0])
			check_slot(slot_valid[0] ? 0 : 1);	// first valid slot
		if (take[1])
			check_slot(1);
		// room when fewer than two pairs hold entries
		ready = (m_pairs.size() < 2);
		if (take[0])
		begin
			if (head_exp[0])
				head_exp[0] = 1'b0;
			else
				head_exp[1] = 1'b0;
		end
		if (take[1])
			head_exp[1] = 1'b0;
		if (m_pairs.size() != 0)
		begin
			if (head_exp == 2'b00)
				void'(m_pairs.pop_front());	// head pair drained
			else
				m_pairs[0] = head_exp;
		end
		if (ready && phit != 2'b00)
			m_pairs.push_back(phit);	// lane l in slot l
		if (ready)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				if (phit[l])
				begin
					pc  = m_pc[l][m_idx[l]];
					tid = {l[0], 4'(m_idx[l])};
					w   = cache_word(pc);
					if (w[6:0] == OP_EXEC)
						q_instr.push_back(codebuf_word(pc));
					else if (w[6:0] == OP_CMP_A || w[6:0] == OP_CMP_B)
						q_instr.push_back(tb_table[{w[6], w[17:7]}]);
					else
						q_instr.push_back(w);
					q_pc.push_back(pc);
					q_tid.push_back(tid);
					q_dc.push_back(w[6:0] == OP_CMP_A || w[6:0] == OP_CMP_B);
					if (!irq_hold[tid])
					begin
						m_pc[l][m_idx[l]] = pc + INSN_BYTES;
						m_idx[l] = (m_idx[l] + 1) % TPL;
					end
				end
			end
		end
		if (wr)
			tb_table[widx] = wdat;	// lands at the coming edge
	endtask

	// ========================================================================
	// phases
	// ========================================================================
	initial
	begin
		{cs, cyc, stb, we} = 4'b0000;
		adr = '0;
		dat = '0;
		irq_hold = '0;
		phit = '0;
		take = 2'b00;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			m_idx[l] = 0;
			for (int t = 0; t < TPL; t++)
				m_pc[l][t] = RST_PC;
		end
		@(negedge clk);
		while (rst)
			@(negedge clk);
		assert (slot_valid == 2'b00 && pc_o[0] == RST_PC && pc_o[1] == RST_PC)
			else fail_check("reset state wrong");

		// full table load, no fetching
		for (int i = 0; i < (1 << TAW); i++)
		begin
			@(negedge clk);
			{cs, cyc, stb, we} = 4'b1111;
			adr = {TAW'(i), 3'b000};
			dat = fill_word(i);
			tb_table[i] = fill_word(i);
		end
		@(negedge clk);
		{cs, cyc, stb, we} = 4'b0000;

		repeat (PHASE_CYCLES / 2) step(1, 1, 0, 0);	// plain running
		repeat (PHASE_CYCLES / 2) step(1, 1, 1, 1);	// holds and rewrites
		repeat (200) step(1, 0, 0, 0);	// back-pressure
		assert (!dut_i.fill_ready)
			else fail_check("pair store never filled under back-pressure");
		while (m_pairs.size() != 0)
			step(0, 1, 0, 0);	// drain
		step(0, 0, 0, 0);	// slots read empty after the last take

		$display(">>> PASS");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout, the run did not finish in %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: dv/tb_clock_gen.sv
// testbench clock and reset
// 10 ns clock, synchronous reset held for 8 cycles
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk_o,
	output logic rst_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;	// 10 ns period
	end

	initial
	begin
		rst_o = 1'b1;
		repeat (8) @(posedge clk_o);	// 8 reset edges
		@(negedge clk_o);
		rst_o = 1'b0;	// release away from the edge
	end

endmodule

// File: hw/barrel_fetchbuf.sv
// barrel fetch buffer top
// decompression table, two thread fetch lanes and the pair store for
// a 32-thread barrel processor
`timescale 1ns/1ps

module barrel_fetchbuf
	import fetch_pkg::*;
#(
	parameter int THREADS_PER_LANE = fetch_pkg::THREADS_PER_LANE,
	parameter int TABLE_AW         = fetch_pkg::TABLE_AW
)
(
	input  logic                                  clk,
	input  logic                                  rst,
	// table write bus
	input  logic                                  cs_i,
	input  logic                                  cyc_i,
	input  logic                                  stb_i,
	input  logic                                  we_i,
	input  logic [BUS_AW-1:0]                     adr_i,
	input  logic [INSN_W-1:0]                     dat_i,
	output logic                                  ack_o,
	// interrupt hold, one bit per thread
	input  logic [NUM_LANES*THREADS_PER_LANE-1:0] irq_hold_i,
	// instruction cache
	output logic [ADDR_W-1:0]                     pc_o [NUM_LANES],
	input  logic [INSN_W-1:0]                     insn_i [NUM_LANES],
	input  logic [NUM_LANES-1:0]                  phit_i,
	input  logic [INSN_W-1:0]                     codebuf_i [NUM_LANES],
	// issue slots
	output logic [1:0]                            slot_valid_o,
	output logic [INSN_W-1:0]                     slot_instr_o [2],
	output logic [ADDR_W-1:0]                     slot_pc_o [2],
	output logic [TID_W-1:0]                      slot_tid_o [2],
	output logic [1:0]                            slot_dc_o,
	input  logic [1:0]                            take_i
);

	// ========================================================================
	// lane wiring
	// ========================================================================
	logic [TABLE_AW-1:0]  table_idx [NUM_LANES];	// lane to table
	logic [INSN_W-1:0]    table_data [NUM_LANES];	// table to lane
	logic [NUM_LANES-1:0] lane_valid;
	logic [INSN_W-1:0]    lane_instr [NUM_LANES];
	logic [ADDR_W-1:0]    lane_pc [NUM_LANES];
	logic [TID_W-1:0]     lane_tid [NUM_LANES];
	logic [NUM_LANES-1:0] lane_dc;
	logic                 fill_ready;	// pair store has room

	decompress_table #(
		.TABLE_AW (TABLE_AW)
	) u_table (
		.clk       (clk),
		.cs_i      (cs_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.ack_o     (ack_o),
		.rd_idx_i  (table_idx),
		.rd_data_o (table_data)
	);

	for (genvar l = 0; l < NUM_LANES; l++)
	begin : g_lane
		thread_fetch_lane #(
			.THREADS_PER_LANE (THREADS_PER_LANE),
			.TABLE_AW         (TABLE_AW)
		) u_lane (
			.clk          (clk),
			.rst          (rst),
			.lane_id_i    (1'(l)),	// lane 1 owns the upper threads
			.pc_o         (pc_o[l]),
			.insn_i       (insn_i[l]),
			.phit_i       (phit_i[l]),
			.codebuf_i    (codebuf_i[l]),
			.irq_hold_i   (irq_hold_i[l*THREADS_PER_LANE +: THREADS_PER_LANE]),
			.table_idx_o  (table_idx[l]),
			.table_data_i (table_data[l]),
			.fill_ready_i (fill_ready),
			.valid_o      (lane_valid[l]),
			.instr_o      (lane_instr[l]),
			.ipc_o        (lane_pc[l]),
			.tid_o        (lane_tid[l]),
			.dc_o         (lane_dc[l])
		);
	end

	fetch_pair_buffer u_pairs (
		.clk          (clk),
		.rst          (rst),
		.valid_i      (lane_valid),
		.instr_i      (lane_instr),
		.pc_i         (lane_pc),
		.tid_i        (lane_tid),
		.dc_i         (lane_dc),
		.fill_ready_o (fill_ready),
		.take_i       (take_i),
		.slot_valid_o (slot_valid_o),
		.slot_instr_o (slot_instr_o),
		.slot_pc_o    (slot_pc_o),
		.slot_tid_o   (slot_tid_o),
		.slot_dc_o    (slot_dc_o)
	);

endmodule

// File: hw/decompress_table.sv
// decompression table
// bus written store of expanded instructions, with one
// asynchronous read port per fetch lane
`timescale 1ns/1ps

module decompress_table
	import fetch_pkg::*;
#(
	parameter int TABLE_AW = fetch_pkg::TABLE_AW	// table index width
)
(
	input  logic                clk,
	// table write bus
	input  logic                cs_i,	// chip select
	input  logic                cyc_i,	// bus cycle
	input  logic                stb_i,	// strobe
	input  logic                we_i,	// write enable
	input  logic [BUS_AW-1:0]   adr_i,	// byte address
	input  logic [INSN_W-1:0]   dat_i,	// expanded instruction
	output logic                ack_o,	// same cycle ack
	// lane read ports
	input  logic [TABLE_AW-1:0] rd_idx_i [NUM_LANES],
	output logic [INSN_W-1:0]   rd_data_o [NUM_LANES]
);

	localparam int DEPTH = 2 ** TABLE_AW;	// entries

	// ========================================================================
	// bus side
	// ========================================================================
	logic [BUS_AW-4:0]   word_adr;	// 8-byte word address
	logic [TABLE_AW-1:0] wr_idx;	// table slot hit by the bus
	logic                bus_sel;	// addressed this cycle

	assign bus_sel  = cs_i & cyc_i & stb_i;
	assign ack_o    = bus_sel;	// zero wait state
	assign word_adr = adr_i[BUS_AW-1:3];	// drop byte lanes
	assign wr_idx   = TABLE_AW'(word_adr);	// fit to table depth

	// ========================================================================
	// storage
	// ========================================================================
	logic [INSN_W-1:0] mem [DEPTH];	// expanded instructions

	always_ff @(posedge clk)
	begin
		if (bus_sel & we_i)
			mem[wr_idx] <= dat_i;	// write on the acked edge
	end

	// one combinational read per lane, same cycle as the cache hit
	for (genvar l = 0; l < NUM_LANES; l++)
	begin : g_rd
		assign rd_data_o[l] = mem[rd_idx_i[l]];
	end

endmodule

// File: hw/fetch_pair_buffer.sv
// fetch pair buffer
// double buffered instruction pairs AB and CD; lane 0 lands in the
// first slot of a pair, lane 1 in the second, and the head pair is
// shown to issue as two in-order slots
`timescale 1ns/1ps

module fetch_pair_buffer
	import fetch_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	// lane side
	input  logic [NUM_LANES-1:0] valid_i,
	input  logic [INSN_W-1:0]    instr_i [NUM_LANES],
	input  logic [ADDR_W-1:0]    pc_i [NUM_LANES],
	input  logic [TID_W-1:0]     tid_i [NUM_LANES],
	input  logic [NUM_LANES-1:0] dc_i,
	output logic                 fill_ready_o,	// shared by both lanes
	// issue side
	input  logic [1:0]           take_i,	// in-order slot accept
	output logic [1:0]           slot_valid_o,
	output logic [INSN_W-1:0]    slot_instr_o [2],
	output logic [ADDR_W-1:0]    slot_pc_o [2],
	output logic [TID_W-1:0]     slot_tid_o [2],
	output logic [1:0]           slot_dc_o
);

	// ========================================================================
	// entries, index {pair, slot}: A=0 B=1 C=2 D=3
	// ========================================================================
	logic [3:0]        ent_v;	// entry valid
	logic [INSN_W-1:0] ent_instr [4];
	logic [ADDR_W-1:0] ent_pc [4];
	logic [TID_W-1:0]  ent_tid [4];
	logic [3:0]        ent_dc;
	logic              head;	// 0 = AB at the head, 1 = CD

	logic [1:0] head_v;	// valids of the head pair
	logic [1:0] other_v;	// valids of the back pair
	logic       fill_sel;	// pair taking the next transfer
	logic [1:0] clr;	// head slots consumed this cycle
	logic [1:0] head_left;	// head slots still valid after takes
	logic       drained;	// head pair emptied by takes

	assign head_v  = head ? ent_v[3:2] : ent_v[1:0];
	assign other_v = head ? ent_v[1:0] : ent_v[3:2];

	// registered valids only, so no path from take_i
	assign fill_ready_o = (head_v == 2'b00) | (other_v == 2'b00);
	assign fill_sel     = (head_v == 2'b00) ? head : ~head;	// head first

	// ========================================================================
	// takes, first valid slot then second
	// ========================================================================
	always_comb
	begin
		clr = 2'b00;
		if (take_i[0])
		begin
			if (head_v[0])
				clr[0] = 1'b1;
			else
				clr[1] = head_v[1];	// only B/D present
		end
		if (take_i[1])
			clr[1] = head_v[1];	// second of two
	end

	assign head_left = head_v & ~clr;
	assign drained   = (head_v != 2'b00) && (head_left == 2'b00);

	// ========================================================================
	// control state
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ent_v <= 4'b0000;
			head  <= 1'b0;
		end
		else
		begin
			ent_v[{head, 1'b0}] <= head_left[0];
			ent_v[{head, 1'b1}] <= head_left[1];
			if (fill_ready_o)
			begin
				for (int l = 0; l < NUM_LANES; l++)
				begin
					if (valid_i[l])
						ent_v[{fill_sel, l[0]}] <= 1'b1;	// lane picks slot
				end
			end
			if (drained)
				head <= ~head;	// flip to the other pair
		end
	end

	// ========================================================================
	// payload
	// ========================================================================
	always_ff @(posedge clk)
	begin
		for (int l = 0; l < NUM_LANES; l++)
		begin
			if (fill_ready_o & valid_i[l])
			begin
				ent_instr[{fill_sel, l[0]}] <= instr_i[l];
				ent_pc[{fill_sel, l[0]}]    <= pc_i[l];
				ent_tid[{fill_sel, l[0]}]   <= tid_i[l];
				ent_dc[{fill_sel, l[0]}]    <= dc_i[l];
			end
		end
	end

	// head pair onto the issue slots
	for (genvar s = 0; s < 2; s++)
	begin : g_slot
		assign slot_valid_o[s] = head_v[s];
		assign slot_instr_o[s] = ent_instr[{head, 1'(s)}];
		assign slot_pc_o[s]    = ent_pc[{head, 1'(s)}];
		assign slot_tid_o[s]   = ent_tid[{head, 1'(s)}];
		assign slot_dc_o[s]    = ent_dc[{head, 1'(s)}];
	end

endmodule

// File: hw/fetch_pkg.sv
// fetch buffer shared definitions
// widths, opcodes, reset pc and the fetched word layout for the
// two-lane barrel fetch buffer
package fetch_pkg;

	// ========================================================================
	// widths and sizes
	// ========================================================================
	parameter int INSN_W           = 36;	// instruction word
	parameter int ADDR_W           = 32;	// program counter
	parameter int NUM_LANES        = 2;	// fetch lanes
	parameter int THREADS_PER_LANE = 16;	// threads per lane
	parameter int TID_W            = 5;	// lane bit + 4-bit index
	parameter int TABLE_AW         = 12;	// decompression table index
	parameter int BUS_AW           = 15;	// byte address on table bus

	// ========================================================================
	// reset and stepping
	// ========================================================================
	parameter logic [ADDR_W-1:0] RST_PC = 32'hFFFC0100;	// boot vector
	parameter int INSN_BYTES = 4;	// pc step per fetch

	// ========================================================================
	// opcodes
	// ========================================================================
	parameter logic [6:0] OP_CMP_A = 7'h10;	// compressed, first form
	parameter logic [6:0] OP_CMP_B = 7'h68;	// compressed, second form
	parameter logic [6:0] OP_EXEC  = 7'h3F;	// take word from code buffer

	// normal view of a fetched word
	typedef struct packed {
		logic [28:0] body;	// everything above the opcode
		logic [6:0]  opcode;	// major opcode
	} fetch_full_t;

	// compressed view, the table index is {index_hi, index_lo}
	typedef struct packed {
		logic [17:0] unused;	// ignored for compressed words
		logic [10:0] index_lo;	// bits 17:7
		logic        index_hi;	// bit 6
		logic [5:0]  low;	// low opcode bits
	} fetch_cmp_t;

	// one fetched word, decoded either way
	typedef union packed {
		fetch_full_t full;
		fetch_cmp_t  cmp;
	} fetch_word_u;

endpackage

// File: hw/thread_fetch_lane.sv
// thread fetch lane
// rotates through its threads, keeps a pc per thread and picks the
// instruction to hand on: raw word, table expansion or code buffer
`timescale 1ns/1ps

module thread_fetch_lane
	import fetch_pkg::*;
#(
	parameter int THREADS_PER_LANE = fetch_pkg::THREADS_PER_LANE,
	parameter int TABLE_AW         = fetch_pkg::TABLE_AW
)
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        lane_id_i,	// top bit of tid
	// cache side
	output logic [ADDR_W-1:0]           pc_o,	// current thread pc
	input  logic [INSN_W-1:0]           insn_i,	// fetched word
	input  logic                        phit_i,	// cache hit
	input  logic [INSN_W-1:0]           codebuf_i,	// exec replacement
	input  logic [THREADS_PER_LANE-1:0] irq_hold_i,	// per thread hold
	// table side
	output logic [TABLE_AW-1:0]         table_idx_o,	// compressed index
	input  logic [INSN_W-1:0]           table_data_i,	// expanded word
	// pair store side
	input  logic                        fill_ready_i,
	output logic                        valid_o,
	output logic [INSN_W-1:0]           instr_o,
	output logic [ADDR_W-1:0]           ipc_o,
	output logic [TID_W-1:0]            tid_o,
	output logic                        dc_o	// came from the table
);

	localparam int IDX_W = (THREADS_PER_LANE > 1) ? $clog2(THREADS_PER_LANE) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(THREADS_PER_LANE - 1);

	// ========================================================================
	// thread rotation and pc table
	// ========================================================================
	logic [IDX_W-1:0]  thr_idx;	// thread being fetched
	logic [ADDR_W-1:0] pc_tbl [THREADS_PER_LANE];	// one pc per thread
	logic              xfer;	// word accepted by the pair store
	logic              advance;	// step pc and thread

	assign pc_o    = pc_tbl[thr_idx];
	assign xfer    = phit_i & fill_ready_i;
	assign advance = xfer & ~irq_hold_i[thr_idx];	// held thread stays put

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < THREADS_PER_LANE; i++)
				pc_tbl[i] <= RST_PC;	// all threads boot together
			thr_idx <= '0;
		end
		else if (advance)
		begin
			pc_tbl[thr_idx] <= pc_o + ADDR_W'(INSN_BYTES);	// sequential
			if (thr_idx == LAST_IDX)
				thr_idx <= '0;	// wrap
			else
				thr_idx <= thr_idx + 1'b1;
		end
	end

	// ========================================================================
	// instruction select
	// ========================================================================
	fetch_word_u word;	// fetched word, both views
	logic        is_cmp;	// compressed opcode
	logic        is_exec;	// exec opcode

	assign word    = insn_i;
	assign is_cmp  = (word.full.opcode == OP_CMP_A) || (word.full.opcode == OP_CMP_B);
	assign is_exec = (word.full.opcode == OP_EXEC);

	// table index is the hi bit above the lo field
	assign table_idx_o = TABLE_AW'({word.cmp.index_hi, word.cmp.index_lo});

	always_comb
	begin
		if (is_exec)
			instr_o = codebuf_i;	// exec wins
		else if (is_cmp)
			instr_o = table_data_i;	// expanded form
		else
			instr_o = insn_i;	// plain
	end

	assign dc_o    = is_cmp;
	assign valid_o = phit_i;	// offer every hit
	assign ipc_o   = pc_o;
	assign tid_o   = TID_W'({lane_id_i, thr_idx});	// lane bit on top

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the barrel fetch buffer simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f barrel_fetchbuf.f \
	--top-module barrel_fetchbuf_tb \
	-o sim_barrel_fetchbuf > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_barrel_fetchbuf > sim.log 2>&1
cat sim.log

grep -q -- ">>> PASS" sim.log \
	&& echo "simulation result: passed" \
	|| { echo "simulation result: failed, see sim.log"; exit 1; }
